/* flist.f */
+incdir+include
rtl/pi1_pkg.sv
rtl/pu_isa_pkg.sv
rtl/pi1_if.sv
rtl/pu.sv
rtl/pi1q.sv
rtl/multipu.sv
sim/multipu_sva.sv
sim/multipu_tb.sv

/* Bender.yml */
package:
  name: multipu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/pi1_pkg.sv
      - rtl/pu_isa_pkg.sv
      - rtl/pi1_if.sv
      - rtl/pu.sv
      - rtl/pi1q.sv
      - rtl/multipu.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/multipu_sva.sv
      - sim/multipu_tb.sv

/* sim/multipu_tb.sv */
// Testbench for the multi-unit subsystem: memory model on the outside pi1 port,
// program loader, reference interpreter and result checks.
`include "multipu_params.svh"

module multipu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pi1_pkg::*;
	import pu_isa_pkg::*;

	localparam int PUCOUNT      = 2;
	localparam int MEMWORDS     = 1024;
	localparam int HALT_TIMEOUT = 4000;
	localparam logic [29:0] RST0 = 30'h010;
	localparam logic [29:0] RST1 = 30'h080;
	localparam logic [31:0] ID   = 32'h0000_c0de;

	logic               clk_i;
	logic               reset_i;
	pi1_op_t            pi1_op_o;
	logic [29:0]        pi1_addr_o;
	logic [31:0]        pi1_data_o;
	logic [31:0]        pi1_data_i;
	logic               pi1_rdy_i;
	logic [29:0]        rstaddr_i;
	logic [29:0]        rstaddr2_i;
	logic [31:0]        id_i;
	logic [PUCOUNT-1:0] halted_o;

	logic [31:0] mem         [MEMWORDS];
	logic [31:0] ref_mem     [MEMWORDS];
	logic [29:0] first_reads [$];
	integer      seed;
	int unsigned wait_left;
	bit          busy;
	int          xfers;
	int          errors;
	int          test_base;
	int          tests_run;
	int          tests_failed;

	multipu #(.PUCOUNT(PUCOUNT)) multipu_inst (
		.clk_i(clk_i), .reset_i(reset_i),
		.pi1_op_o(pi1_op_o), .pi1_addr_o(pi1_addr_o), .pi1_data_o(pi1_data_o),
		.pi1_data_i(pi1_data_i), .pi1_rdy_i(pi1_rdy_i),
		.rstaddr_i(rstaddr_i), .rstaddr2_i(rstaddr2_i), .id_i(id_i), .halted_o(halted_o)
	);

	always #5 clk_i = ~clk_i;

	function automatic logic [31:0] fill_word(int a);
		return (32'(a) * 32'h9e37_79b9) ^ 32'h5eed_0000;
	endfunction

	function automatic logic [31:0] mem_insn(pu_opc_t opc, logic [29:0] addr);
		return {opc, addr[27:0]};
	endfunction

	function automatic logic [31:0] alu_insn(pu_alu_t fn, logic [23:0] imm);
		return {OPC_ALU, fn, imm};
	endfunction

	function automatic logic [29:0] data_addr(int u, int k);
		return 30'(32'h200 + u * 32'h40 + k); // Each unit gets its own data words.
	endfunction

	// Interprets one unit's program on ref_mem until HALT or an undefined opcode.
	function automatic void run_reference(logic [29:0] start, logic [31:0] id);
		logic [29:0] pc;
		logic [31:0] acc;
		logic [31:0] w;
		bit          done;
		pc   = start;
		acc  = '0;
		done = 1'b0;
		for (int step = 0; step < 256 && !done; step++) begin
			w  = ref_mem[pc[9:0]];
			pc = pc + 1'b1;
			case (w[31:28])
			OPC_LDA:   acc = ref_mem[w[9:0]];
			OPC_STA:   ref_mem[w[9:0]] = acc;
			OPC_CPUID: acc = id;
			OPC_JMP:   pc = 30'(w[27:0]);
			OPC_ALU: begin
				if (w[27:24] == ALU_LDI) acc = {8'h00, w[23:0]};
				else if (w[27:24] == ALU_ADD) acc = acc + {8'h00, w[23:0]};
				else if (w[27:24] == ALU_XOR) acc = acc ^ {8'h00, w[23:0]};
			end
			default:   done = 1'b1;
			endcase
		end
	endfunction

	task automatic load_program(int u, logic [29:0] base);
		logic [29:0] d;
		d = data_addr(u, 0);
		mem[base + 0]  = alu_insn(ALU_LDI, 24'h001234 + 24'(u));
		mem[base + 1]  = alu_insn(ALU_ADD, 24'h000f0f);
		mem[base + 2]  = alu_insn(ALU_XOR, 24'h5a5a5a);
		mem[base + 3]  = mem_insn(OPC_STA, d + 0);
		mem[base + 4]  = mem_insn(OPC_CPUID, '0);
		mem[base + 5]  = mem_insn(OPC_STA, d + 1);
		mem[base + 6]  = mem_insn(OPC_LDA, d + 2); // Word d+2 keeps its fill value.
		mem[base + 7]  = alu_insn(ALU_ADD, 24'h000003);
		mem[base + 8]  = mem_insn(OPC_JMP, base + 10);
		mem[base + 9]  = mem_insn(OPC_STA, d + 3); // Must be jumped over.
		mem[base + 10] = mem_insn(OPC_STA, d + 4);
		mem[base + 11] = mem_insn(OPC_HALT, '0);
	endtask

	task automatic report_value(string name, logic [31:0] exp, logic [31:0] act);
		$display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic report_problem(string what);
		$display("problem at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(int num, string name);
		tests_run++;
		if (errors == test_base) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errors - test_base);
			tests_failed++;
		end
		test_base = errors;
	endtask

	// Outside memory: a request seen at one edge gets rdy after 0 to 3 further cycles.
	always @(posedge clk_i) begin
		if (pi1_op_o != PI1_NONE && pi1_rdy_i) begin
			if (pi1_op_o == PI1_WRITE) begin
				mem[pi1_addr_o[9:0]] = pi1_data_o;
			end else if (first_reads.size() < 2) begin
				first_reads.push_back(pi1_addr_o);
			end
			xfers++;
			busy = 1'b0;
			#1 pi1_rdy_i = 1'b0;
		end else if (pi1_op_o != PI1_NONE) begin
			if (!busy) begin
				busy      = 1'b1;
				wait_left = $unsigned($random(seed)) % 4;
			end
			#1;
			if (wait_left == 0) begin
				pi1_rdy_i  = 1'b1;
				pi1_data_i = (pi1_op_o == PI1_READ) ? mem[pi1_addr_o[9:0]] : '0;
			end else begin
				wait_left--;
			end
		end
	end

	initial begin
		logic [PUCOUNT-1:0] seen_halted;
		int                 xfers_at_halt;
		bit                 stalled;
		logic [29:0]        d;
		seed = 32'hd120_7c00;
		clk_i = 1'b0;
		reset_i = 1'b1;
		pi1_data_i = '0;
		pi1_rdy_i = 1'b0;
		rstaddr_i = RST0;
		rstaddr2_i = RST1;
		id_i = ID;
		{busy, xfers, errors, test_base, tests_run, tests_failed} = '0;
		for (int a = 0; a < MEMWORDS; a++) mem[a] = fill_word(a);
		load_program(0, RST0);
		load_program(1, RST1);
		ref_mem = mem;
		run_reference(RST0, ID);
		run_reference(RST1, ID + 1);

		for (int k = 0; k < 4; k++) begin
			@(posedge clk_i);
			#1;
			if (pi1_op_o !== PI1_NONE) report_value("pi1_op_o", PI1_NONE, pi1_op_o);
			if (halted_o !== '0) report_value("halted_o", '0, halted_o);
		end
		reset_i = 1'b0;

		stalled = 1'b1;
		seen_halted = '0;
		for (int t = 0; t < HALT_TIMEOUT; t++) begin
			@(posedge clk_i);
			#1;
			if ((seen_halted & ~halted_o) != '0) report_problem("a halted unit started again");
			seen_halted = seen_halted | halted_o;
			if (&halted_o) begin
				stalled = 1'b0;
				break;
			end
		end

		if (first_reads.size() < 2) begin
			report_problem("fewer than two reads reached the outside port");
		end else begin
			if (first_reads[0] !== RST0) report_value("first read addr", RST0, first_reads[0]);
			if (first_reads[1] !== RST1) report_value("second read addr", RST1, first_reads[1]);
		end
		end_test(1, "reset and first fetch");

		for (int u = 0; u < PUCOUNT; u++) begin
			d = data_addr(u, 0);
			if (mem[d] !== ref_mem[d]) report_value($sformatf("mem[%0h]", d), ref_mem[d], mem[d]);
		end
		end_test(2, "alu and store");

		for (int u = 0; u < PUCOUNT; u++) begin
			d = data_addr(u, 1);
			if (mem[d] !== ID + u) report_value($sformatf("mem[%0h]", d), ID + u, mem[d]);
		end
		end_test(3, "cpuid");

		for (int u = 0; u < PUCOUNT; u++) begin
			d = data_addr(u, 3);
			if (mem[d] !== fill_word(d)) report_value($sformatf("mem[%0h]", d), fill_word(d), mem[d]);
		end
		for (int a = 0; a < MEMWORDS; a++) begin
			if (mem[a] !== ref_mem[a]) report_value($sformatf("mem[%0h]", a), ref_mem[a], mem[a]);
		end
		end_test(4, "load and jump");

		if (stalled) begin
			report_problem($sformatf("units did not all halt within %0d cycles, halted_o = %b",
				HALT_TIMEOUT, halted_o));
		end else begin
			xfers_at_halt = xfers;
			repeat (20) begin
				@(posedge clk_i);
				#1;
				if (pi1_op_o !== PI1_NONE) report_value("pi1_op_o", PI1_NONE, pi1_op_o);
			end
			if (xfers != xfers_at_halt) report_problem("bus transfers happened after all units halted");
		end
		if (multipu_inst.pi1q_inst.multipu_sva_inst.assert_fails != 0) begin
			report_problem("bus protocol assertions failed");
		end
		end_test(5, "halt and fairness");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sim/multipu_sva.sv */
// Bus protocol and arbitration checks for the pi1 arbiter, attached to pi1q by bind.
`include "multipu_params.svh"

module multipu_sva #(
	parameter int PUCOUNT = `MULTIPU_PUCOUNT
) (
	input logic                          clk_i,
	input logic                          reset_i,
	input pi1_pkg::pi1_op_t              op_i,
	input logic [`MULTIPU_ADDRBITSZ-1:0] addr_i,
	input logic [`MULTIPU_ARCHBITSZ-1:0] wdata_i,
	input logic                          rdy_i,
	input logic [PUCOUNT-1:0]            gnt_i,
	pi1_if.slave                         m [PUCOUNT]
);
	timeunit 1ns;
	timeprecision 100ps;
	import pi1_pkg::*;

	int assert_fails = 0; // Read by the testbench at the end of the run.
	logic [PUCOUNT-1:0] req;

	// An outside request that is still waiting must not change under the slave.
	assert property (@(posedge clk_i) disable iff (reset_i)
		(op_i != PI1_NONE && !rdy_i) |=> $stable(op_i) && $stable(addr_i) && $stable(wdata_i))
	else begin
		assert_fails++;
		$error("outside request changed before rdy");
	end

	// The grant belongs to at most one master, and only to one that is requesting.
	assert property (@(posedge clk_i) disable iff (reset_i)
		$onehot0(gnt_i) && ((gnt_i & ~req) == '0))
	else begin
		assert_fails++;
		$error("grant held by more than one master or by an idle master");
	end

	for (genvar g = 0; g < PUCOUNT; g++) begin : gen_rdy
		assign req[g] = (m[g].op != PI1_NONE);

		// Only the master whose request is on the outside port may see rdy.
		assert property (@(posedge clk_i) disable iff (reset_i)
			m[g].rdy |-> gnt_i[g] && op_i == m[g].op && addr_i == m[g].addr
				&& wdata_i == m[g].wdata)
		else begin
			assert_fails++;
			$error("master %0d saw rdy without its request on the outside port", g);
		end
	end

endmodule

bind pi1q multipu_sva #(.PUCOUNT(PUCOUNT)) multipu_sva_inst (
	.clk_i   (clk_i),
	.reset_i (reset_i),
	.op_i    (pi1_op_o),
	.addr_i  (pi1_addr_o),
	.wdata_i (pi1_data_o),
	.rdy_i   (pi1_rdy_i),
	.gnt_i   (gnt),
	.m       (m)
);

/* rtl/multipu.sv */
// Top level of the multi-unit subsystem: PUCOUNT processing units sharing one
// outside pi1 port through a round-robin arbiter.
`include "multipu_params.svh"

module multipu #(
	parameter int PUCOUNT = `MULTIPU_PUCOUNT
) (
	input  logic                          clk_i,
	input  logic                          reset_i,
	output pi1_pkg::pi1_op_t              pi1_op_o,
	output logic [`MULTIPU_ADDRBITSZ-1:0] pi1_addr_o,
	output logic [`MULTIPU_ARCHBITSZ-1:0] pi1_data_o,
	input  logic [`MULTIPU_ARCHBITSZ-1:0] pi1_data_i,
	input  logic                          pi1_rdy_i,
	input  logic [`MULTIPU_ADDRBITSZ-1:0] rstaddr_i,  // Start of unit 0.
	input  logic [`MULTIPU_ADDRBITSZ-1:0] rstaddr2_i, // Start of every other unit.
	input  logic [`MULTIPU_ARCHBITSZ-1:0] id_i,
	output logic [PUCOUNT-1:0]            halted_o
);
	localparam int ARCHBITSZ = `MULTIPU_ARCHBITSZ;

	pi1_if pu_bus [PUCOUNT] ();

	for (genvar g = 0; g < PUCOUNT; g++) begin : gen_pu
		// Each unit reports id_i plus its own index.
		pu pu_inst (
			.clk_i     (clk_i),
			.reset_i   (reset_i),
			.rstaddr_i ((g == 0) ? rstaddr_i : rstaddr2_i),
			.id_i      (id_i + ARCHBITSZ'(g)),
			.bus       (pu_bus[g]),
			.halted_o  (halted_o[g])
		);
	end

	pi1q #(
		.PUCOUNT (PUCOUNT)
	) pi1q_inst (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.m          (pu_bus),
		.pi1_op_o   (pi1_op_o),
		.pi1_addr_o (pi1_addr_o),
		.pi1_data_o (pi1_data_o),
		.pi1_data_i (pi1_data_i),
		.pi1_rdy_i  (pi1_rdy_i)
	);

endmodule

/* rtl/pi1q.sv */
// Round-robin arbiter that merges PUCOUNT pi1 masters onto one outside pi1 port.
// The grant is registered; rdy and read data go back combinationally.
`include "multipu_params.svh"

module pi1q #(
	parameter int PUCOUNT = `MULTIPU_PUCOUNT
) (
	input  logic                          clk_i,
	input  logic                          reset_i,
	pi1_if.slave                          m [PUCOUNT],
	output pi1_pkg::pi1_op_t              pi1_op_o,
	output logic [`MULTIPU_ADDRBITSZ-1:0] pi1_addr_o,
	output logic [`MULTIPU_ARCHBITSZ-1:0] pi1_data_o,
	input  logic [`MULTIPU_ARCHBITSZ-1:0] pi1_data_i,
	input  logic                          pi1_rdy_i
);
	import pi1_pkg::*;

	localparam int IDXBITSZ = (PUCOUNT > 1) ? $clog2(PUCOUNT) : 1;

	pi1_op_t                       op_a   [PUCOUNT];
	logic [`MULTIPU_ADDRBITSZ-1:0] addr_a [PUCOUNT];
	logic [`MULTIPU_ARCHBITSZ-1:0] data_a [PUCOUNT];
	logic [PUCOUNT-1:0]            req;
	logic [PUCOUNT-1:0]            gnt;     // One-hot view of the held grant.
	logic                          gnt_vld;
	logic [IDXBITSZ-1:0]           gnt_idx;
	logic [IDXBITSZ-1:0]           rr_ptr;  // Master searched first at the next arbitration.
	logic                          pick_vld;
	logic [IDXBITSZ-1:0]           pick;

	for (genvar g = 0; g < PUCOUNT; g++) begin : gen_m
		assign op_a[g]    = m[g].op;
		assign addr_a[g]  = m[g].addr;
		assign data_a[g]  = m[g].wdata;
		assign req[g]     = (m[g].op != PI1_NONE);
		assign gnt[g]     = gnt_vld && (gnt_idx == IDXBITSZ'(g));
		assign m[g].rdy   = gnt[g] && pi1_rdy_i; // Waiting masters never see rdy.
		assign m[g].rdata = gnt[g] ? pi1_data_i : '0;
	end

	// Lowest offset from rr_ptr wins, so the loop runs from the far end down.
	always_comb begin
		int unsigned idx;
		pick_vld = 1'b0;
		pick     = rr_ptr;
		for (int k = PUCOUNT - 1; k >= 0; k--) begin
			idx = (int'(rr_ptr) + k) % PUCOUNT;
			if (req[idx]) begin
				pick_vld = 1'b1;
				pick     = IDXBITSZ'(idx);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			gnt_vld <= 1'b0;
			gnt_idx <= '0;
			rr_ptr  <= '0;
		end else if (gnt_vld) begin
			if (pi1_rdy_i) begin
				gnt_vld <= 1'b0; // Released in the completing cycle.
				rr_ptr  <= (gnt_idx == IDXBITSZ'(PUCOUNT - 1)) ? '0 : gnt_idx + 1'b1;
			end
		end else if (pick_vld) begin
			gnt_vld <= 1'b1;
			gnt_idx <= pick;
		end
	end

	assign pi1_op_o   = gnt_vld ? op_a[gnt_idx] : PI1_NONE;
	assign pi1_addr_o = addr_a[gnt_idx];
	assign pi1_data_o = data_a[gnt_idx];

endmodule

/* rtl/pu.sv */
// Small accumulator processing unit. It fetches one word per instruction over a
// pi1 master link and stops for good on HALT or on any undefined opcode.
`include "multipu_params.svh"

module pu (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic [`MULTIPU_ADDRBITSZ-1:0] rstaddr_i,
	input  logic [`MULTIPU_ARCHBITSZ-1:0] id_i,
	pi1_if.master                         bus,
	output logic                          halted_o
);
	import pi1_pkg::*;
	import pu_isa_pkg::*;

	localparam int ARCHBITSZ = `MULTIPU_ARCHBITSZ;
	localparam int ADDRBITSZ = `MULTIPU_ADDRBITSZ;

	typedef enum logic [1:0] {
		S_FETCH,
		S_DATA,
		S_EXEC,
		S_HALT
	} state_t;

	state_t               state;
	logic [ADDRBITSZ-1:0] pc;
	logic [ARCHBITSZ-1:0] acc;
	logic [ARCHBITSZ-1:0] mdr;     // Word read by LDA, used in the execute cycle.
	pu_insn_u             ir;
	pu_insn_u             fetched;
	logic                 fetched_mem;
	logic [ADDRBITSZ-1:0] ea;
	logic [ARCHBITSZ-1:0] imm;
	logic [ARCHBITSZ-1:0] alu_res;

	assign fetched = bus.rdata;

	// Only loads and stores need a second bus transfer.
	assign fetched_mem = (fetched.mem.opc == OPC_LDA) || (fetched.mem.opc == OPC_STA);

	assign ea  = ADDRBITSZ'(ir.mem.addr); // Zero-extended word address.
	assign imm = ARCHBITSZ'(ir.alu.imm);

	assign halted_o = (state == S_HALT);

	always_comb begin
		case (ir.alu.fn)
		ALU_LDI: alu_res = imm;
		ALU_ADD: alu_res = acc + imm;
		ALU_XOR: alu_res = acc ^ imm;
		default: alu_res = acc; // Unknown functions leave the accumulator alone.
		endcase
	end

	// Requests are held by the state itself until rdy moves the sequencer on.
	always_comb begin
		bus.op    = PI1_NONE;
		bus.addr  = pc;
		bus.wdata = acc;
		case (state)
		S_FETCH: begin
			bus.op = reset_i ? PI1_NONE : PI1_READ; // The first fetch follows reset.
		end
		S_DATA: begin
			bus.op   = (ir.mem.opc == OPC_STA) ? PI1_WRITE : PI1_READ;
			bus.addr = ea;
		end
		default: begin
			bus.op = PI1_NONE;
		end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (state == S_FETCH && bus.rdy) begin
			ir <= fetched;
		end
		if (state == S_DATA && bus.rdy) begin
			mdr <= bus.rdata;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_FETCH;
			pc    <= rstaddr_i;
			acc   <= '0;
		end else begin
			case (state)
			S_FETCH: begin
				if (bus.rdy) begin
					state <= fetched_mem ? S_DATA : S_EXEC;
				end
			end
			S_DATA: begin
				if (bus.rdy) begin
					state <= S_EXEC;
				end
			end
			S_EXEC: begin
				state <= S_FETCH;
				pc    <= pc + 1'b1;
				case (ir.mem.opc)
				OPC_LDA:   acc   <= mdr;
				OPC_STA:   acc   <= acc; // The write already happened in S_DATA.
				OPC_ALU:   acc   <= alu_res;
				OPC_CPUID: acc   <= id_i;
				OPC_JMP:   pc    <= ea;
				default:   state <= S_HALT; // HALT and undefined opcodes.
				endcase
			end
			default: begin
				state <= S_HALT;
			end
			endcase
		end
	end

endmodule

/* rtl/pi1_if.sv */
// One pi1 link between a bus master and the arbiter.
// The master holds op, addr and wdata until it sees rdy high.
`include "multipu_params.svh"

interface pi1_if;
	import pi1_pkg::*;

	pi1_op_t                       op;
	logic [`MULTIPU_ADDRBITSZ-1:0] addr;
	logic [`MULTIPU_ARCHBITSZ-1:0] wdata;
	logic [`MULTIPU_ARCHBITSZ-1:0] rdata; // Valid in the rdy cycle of a read.
	logic                          rdy;

	modport master (
		output op, addr, wdata,
		input  rdata, rdy
	);

	modport slave (
		input  op, addr, wdata,
		output rdata, rdy
	);

endinterface

/* rtl/pu_isa_pkg.sv */
// Instruction set of the processing unit: opcodes, ALU functions and the word layout.
// Used by the unit itself and by anything that builds or interprets programs.
`include "multipu_params.svh"

package pu_isa_pkg;

	localparam int PU_MADDRBITSZ = `MULTIPU_ARCHBITSZ - `MULTIPU_OPCBITSZ;
	localparam int PU_IMMBITSZ   = `MULTIPU_ARCHBITSZ - 2 * `MULTIPU_OPCBITSZ;

	typedef enum logic [`MULTIPU_OPCBITSZ-1:0] {
		OPC_HALT  = 4'h0, // A cleared word halts the unit.
		OPC_LDA   = 4'h1,
		OPC_STA   = 4'h2,
		OPC_ALU   = 4'h3,
		OPC_CPUID = 4'h4,
		OPC_JMP   = 4'h5
	} pu_opc_t;

	typedef enum logic [`MULTIPU_OPCBITSZ-1:0] {
		ALU_LDI = 4'h0,
		ALU_ADD = 4'h1,
		ALU_XOR = 4'h2
	} pu_alu_t;

	// Layout used by LDA, STA and JMP.
	typedef struct packed {
		pu_opc_t                  opc;
		logic [PU_MADDRBITSZ-1:0] addr;
	} pu_mem_insn_t;

	// Layout used by ALU.
	typedef struct packed {
		pu_opc_t                opc;
		pu_alu_t                fn;
		logic [PU_IMMBITSZ-1:0] imm;
	} pu_alu_insn_t;

	typedef union packed {
		pu_mem_insn_t mem;
		pu_alu_insn_t alu;
	} pu_insn_u;

endpackage

/* rtl/pi1_pkg.sv */
// Types of the pi1 bus, shared by the masters, the arbiter and the top level.
package pi1_pkg;

	// Operation code of a pi1 request; rdy is only looked at while op is not PI1_NONE.
	typedef enum logic [1:0] {
		PI1_NONE  = 2'b00, // Idle.
		PI1_WRITE = 2'b01,
		PI1_READ  = 2'b10
		// Code 2'b11 is reserved.
	} pi1_op_t;

endpackage

/* include/multipu_params.svh */
// Width and count defaults shared by the multi-unit design.
// Include this file wherever one of the widths is needed.
`ifndef MULTIPU_PARAMS_SVH
`define MULTIPU_PARAMS_SVH

// Data and instruction word width.
`define MULTIPU_ARCHBITSZ 32

// Word address width, so one address step is one full word.
`define MULTIPU_ADDRBITSZ 30

// Default number of processing units on the shared bus.
`define MULTIPU_PUCOUNT 2

// Width of the opcode field at the top of each instruction word.
`define MULTIPU_OPCBITSZ 4

`endif
